// ==== src/cart_pkg.sv ====
// package with controller kind and register region enums, header offsets and field widths
package cart_pkg;

	// ------------------------------------------------------------------------
	// field widths
	// ------------------------------------------------------------------------

	localparam int ROM_BANK_W  = 9;   // up to 512 ROM banks of 16 KB (MBC5)
	localparam int RAM_BANK_W  = 4;   // up to 16 RAM banks of 8 KB
	localparam int DL_ADDR_W   = 25;  // byte address of the download stream
	localparam int ROM_WADDR_W = 22;  // 16-bit word address into external ROM

	// ------------------------------------------------------------------------
	// cartridge header
	// ------------------------------------------------------------------------

	// the stream carries 16-bit words at even byte offsets, so each constant
	// names the even word address and the wanted byte sits in one half of it
	localparam logic [DL_ADDR_W-1:0] HDR_CGB_ADDR  = 25'h142;  // colour flag in high byte (143h)
	localparam logic [DL_ADDR_W-1:0] HDR_TYPE_ADDR = 25'h146;  // cart type in high byte (147h)
	localparam logic [DL_ADDR_W-1:0] HDR_SIZE_ADDR = 25'h148;  // rom size low, ram size high

	// colour flag values that mark a colour game
	localparam logic [7:0] CGB_FLAG_COMPAT = 8'h80;
	localparam logic [7:0] CGB_FLAG_ONLY   = 8'hC0;

	// low nibble written to 0000-1FFF that opens the RAM
	localparam logic [3:0] RAM_ENABLE_KEY = 4'hA;

	// ------------------------------------------------------------------------
	// enums
	// ------------------------------------------------------------------------

	// memory bank controller fitted on the cartridge
	typedef enum logic [2:0] {
		MBC_NONE = 3'd0,  // 32 KB ROM, linear
		MBC_1    = 3'd1,
		MBC_2    = 3'd2,  // built-in 512 x 4 bit RAM
		MBC_3    = 3'd3,  // clock registers share A000-BFFF with RAM
		MBC_5    = 3'd5
	} mbc_kind_t;

	// register targeted by a CPU write into the ROM area, from cpu_addr[14:13]
	typedef enum logic [1:0] {
		REG_RAM_EN   = 2'd0,  // 0000-1FFF
		REG_ROM_BANK = 2'd1,  // 2000-3FFF
		REG_RAM_BANK = 2'd2,  // 4000-5FFF
		REG_MODE     = 2'd3   // 6000-7FFF
	} reg_region_t;

endpackage

// ==== src/cart_header.sv ====
// header byte capture from the download stream with controller kind and mask decode
module cart_header (
	input  logic                           clk_sys,
	input  logic                           reset,
	input  logic                           dl_active,
	input  logic                           dl_wr,
	input  logic [cart_pkg::DL_ADDR_W-1:0] dl_addr,
	input  logic [15:0]                    dl_data,
	output cart_pkg::mbc_kind_t            mbc_kind,
	output logic [cart_pkg::ROM_BANK_W-1:0] rom_mask,
	output logic [cart_pkg::RAM_BANK_W-1:0] ram_mask,
	output logic                           ram_present,
	output logic                           cgb_game
);
	import cart_pkg::*;

	logic [7:0] cart_type;  // 147h
	logic [7:0] rom_size;   // 148h
	logic [7:0] ram_size;   // 149h
	logic [7:0] cgb_flag;   // 143h

	// ------------------------------------------------------------------------
	// capture
	// ------------------------------------------------------------------------

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			cart_type <= '0;
			rom_size  <= '0;
			ram_size  <= '0;
			cgb_flag  <= '0;
		end else if (dl_active && dl_wr) begin
			// odd header bytes come in the high half of the word
			if (dl_addr == HDR_CGB_ADDR)
				cgb_flag <= dl_data[15:8];
			if (dl_addr == HDR_TYPE_ADDR)
				cart_type <= dl_data[15:8];
			if (dl_addr == HDR_SIZE_ADDR) begin
				rom_size <= dl_data[7:0];   // even byte
				ram_size <= dl_data[15:8];  // odd byte
			end
		end
	end

	// ------------------------------------------------------------------------
	// decode
	// ------------------------------------------------------------------------

	always_comb begin
		case (cart_type) inside
			[8'h01:8'h03]: mbc_kind = MBC_1;  // plain, +RAM, +RAM+battery
			[8'h05:8'h06]: mbc_kind = MBC_2;
			[8'h0F:8'h13]: mbc_kind = MBC_3;  // with and without clock
			[8'h19:8'h1E]: mbc_kind = MBC_5;  // incl. rumble variants
			default:       mbc_kind = MBC_NONE;
		endcase
	end

	// size code n means 2^(n+1) banks, so n+1 low ones
	always_comb begin
		if (rom_size <= 8'd8)
			rom_mask = 9'h1FF >> (4'd8 - rom_size[3:0]);
		else
			rom_mask = 9'h07F;  // odd 52h-54h sizes get a 128 bank window
	end

	always_comb begin
		case (ram_size)
			8'd0, 8'd1, 8'd2: ram_mask = 4'h0;  // none, 2 KB or 8 KB in one bank
			8'd3:             ram_mask = 4'h3;  // 32 KB in four banks
			default:          ram_mask = 4'hF;  // 128 KB and up
		endcase
	end

	// MBC2 carries its own RAM whatever the size byte says
	assign ram_present = (ram_size != 8'd0) || (mbc_kind == MBC_2);
	assign cgb_game    = (cgb_flag == CGB_FLAG_COMPAT) || (cgb_flag == CGB_FLAG_ONLY);

endmodule

// ==== src/mbc_regs.sv ====
// controller registers written by the CPU in 0000-7FFF with per-controller update rules
module mbc_regs (
	input  logic                            clk_sys,
	input  logic                            reset,
	input  logic                            dl_active,
	input  logic [15:0]                     cpu_addr,
	input  logic                            cpu_wr,
	input  logic [7:0]                      cpu_wdata,
	input  cart_pkg::mbc_kind_t             mbc_kind,
	output logic [cart_pkg::ROM_BANK_W-1:0] rom_bank,
	output logic [cart_pkg::RAM_BANK_W-1:0] ram_bank,
	output logic                            mbc1_mode,
	output logic                            rtc_mode,
	output logic                            ram_enabled
);
	import cart_pkg::*;

	reg_region_t region;     // which register the write hits
	logic        reg_wr;     // write into the ROM area with a controller fitted
	logic [6:0]  wr_bank;    // MBC1-3 bank value, zero already mapped to 1

	// ------------------------------------------------------------------------
	// write decode
	// ------------------------------------------------------------------------

	always_comb begin
		case (cpu_addr[14:13])
			2'd0:    region = REG_RAM_EN;
			2'd1:    region = REG_ROM_BANK;
			2'd2:    region = REG_RAM_BANK;
			default: region = REG_MODE;
		endcase
	end

	// no controller means nothing in 0000-7FFF listens
	assign reg_wr = cpu_wr && !cpu_addr[15] && (mbc_kind != MBC_NONE);

	// bank register width differs per controller
	always_comb begin
		case (mbc_kind)
			MBC_1:   wr_bank = {2'b00, cpu_wdata[4:0]};  // 5 bits
			MBC_2:   wr_bank = {3'b000, cpu_wdata[3:0]}; // 4 bits
			default: wr_bank = cpu_wdata[6:0];            // MBC3 uses 7 bits
		endcase
		if (wr_bank == 7'd0)
			wr_bank = 7'd1;  // bank 0 is never mapped at 4000h
	end

	// ------------------------------------------------------------------------
	// registers
	// ------------------------------------------------------------------------

	always_ff @(posedge clk_sys) begin
		if (reset || dl_active) begin
			// a new cartridge image starts from power-on values
			rom_bank    <= {{(ROM_BANK_W-1){1'b0}}, 1'b1};
			ram_bank    <= '0;
			mbc1_mode   <= 1'b0;
			rtc_mode    <= 1'b0;
			ram_enabled <= 1'b0;
		end else if (reg_wr) begin
			case (region)
				REG_RAM_EN: begin
					ram_enabled <= (cpu_wdata[3:0] == RAM_ENABLE_KEY);
				end
				REG_ROM_BANK: begin
					if (mbc_kind == MBC_5) begin
						// MBC5 splits the 9-bit bank, and 0 is a legal bank
						if (cpu_addr[12])
							rom_bank[8] <= cpu_wdata[0];   // 3000-3FFF
						else
							rom_bank[7:0] <= cpu_wdata;    // 2000-2FFF
					end else begin
						rom_bank <= {{(ROM_BANK_W-7){1'b0}}, wr_bank};
					end
				end
				REG_RAM_BANK: begin
					case (mbc_kind)
						MBC_3: begin
							// bit 3 picks a clock register instead of RAM
							if (cpu_wdata[3]) begin
								rtc_mode <= 1'b1;
							end else begin
								rtc_mode <= 1'b0;
								ram_bank <= {2'b00, cpu_wdata[1:0]};
							end
						end
						MBC_5:   ram_bank <= cpu_wdata[3:0];       // 16 banks
						default: ram_bank <= {2'b00, cpu_wdata[1:0]};
					endcase
				end
				REG_MODE: begin
					if (mbc_kind == MBC_1)
						mbc1_mode <= cpu_wdata[0];  // 0 = ROM banking, 1 = RAM banking
				end
				default: ;
			endcase
		end
	end

endmodule

// ==== src/cart_addr_map.sv ====
// ROM word address, cart RAM address and write strobe, and RAM read masking
module cart_addr_map #(
	parameter int CRAM_BANK_BITS = 4
) (
	input  logic                             clk_sys,
	input  logic [15:0]                      cpu_addr,
	input  logic                             cpu_rd,
	input  logic                             cpu_wr,
	input  logic [7:0]                       cpu_wdata,
	input  cart_pkg::mbc_kind_t              mbc_kind,
	input  logic [cart_pkg::ROM_BANK_W-1:0]  rom_mask,
	input  logic [cart_pkg::RAM_BANK_W-1:0]  ram_mask,
	input  logic [cart_pkg::ROM_BANK_W-1:0]  rom_bank,
	input  logic [cart_pkg::RAM_BANK_W-1:0]  ram_bank,
	input  logic                             mbc1_mode,
	input  logic                             rtc_mode,
	input  logic                             ram_enabled,
	output logic [cart_pkg::ROM_WADDR_W-1:0] rom_waddr,
	output logic                             rom_byte_hi,
	output logic [CRAM_BANK_BITS+12:0]       cram_addr,
	output logic                             cram_we,
	output logic [7:0]                       cram_wdata,
	output logic [7:0]                       cpu_rdata,
	input  logic [7:0]                       cram_q
);
	import cart_pkg::*;

	typedef enum logic [1:0] {RD_RAM, RD_OFF, RD_NIBBLE, RD_CLOCK} rd_sel_t;

	logic [ROM_BANK_W-1:0]      rom_bank_eff;
	logic [RAM_BANK_W-1:0]      ram_bank_eff;
	logic                       is_cram;          // A000-BFFF
	logic [CRAM_BANK_BITS+12:0] cram_addr_live;
	logic [CRAM_BANK_BITS+12:0] cram_addr_hold;   // address of the last RAM read
	rd_sel_t                    rd_sel, rd_sel_q;

	// ------------------------------------------------------------------------
	// ROM side
	// ------------------------------------------------------------------------

	always_comb begin
		if (!cpu_addr[14])
			rom_bank_eff = '0;  // 0000-3FFF is always bank 0
		else begin
			case (mbc_kind)
				MBC_NONE: rom_bank_eff = 9'd1;  // 32 KB linear
				// mode 0 hands the two RAM bank bits to ROM bank bits 5-6
				MBC_1: rom_bank_eff = {2'b00, (mbc1_mode ? 2'b00 : ram_bank[1:0]),
					rom_bank[4:0]} & rom_mask;
				default: rom_bank_eff = rom_bank & rom_mask;  // mirror small ROMs
			endcase
		end
	end

	assign rom_waddr   = {rom_bank_eff, cpu_addr[13:1]};  // 8192 words per bank
	assign rom_byte_hi = cpu_addr[0];                     // odd byte is the high half

	// ------------------------------------------------------------------------
	// cart RAM side
	// ------------------------------------------------------------------------

	always_comb begin
		case (mbc_kind)
			MBC_1:        ram_bank_eff = mbc1_mode ? (ram_bank & ram_mask) : '0;
			MBC_3, MBC_5: ram_bank_eff = ram_bank & ram_mask;
			default:      ram_bank_eff = '0;  // single bank, or no banking at all
		endcase
	end

	assign is_cram        = (cpu_addr[15:13] == 3'b101);
	assign cram_addr_live = {ram_bank_eff[CRAM_BANK_BITS-1:0], cpu_addr[12:0]};

	// between accesses keep pointing at the last read so its data stays on cram_q
	assign cram_addr  = (is_cram && (cpu_rd || cpu_wr)) ? cram_addr_live : cram_addr_hold;
	assign cram_we    = cpu_wr && is_cram && ram_enabled && !rtc_mode;
	assign cram_wdata = cpu_wdata;

	// masking case is fixed by the controller state at the time of the read
	always_comb begin
		if (!ram_enabled)
			rd_sel = RD_OFF;
		else if (mbc_kind == MBC_2)
			rd_sel = RD_NIBBLE;
		else if (rtc_mode)
			rd_sel = RD_CLOCK;
		else
			rd_sel = RD_RAM;
	end

	always_ff @(posedge clk_sys) begin
		if (cpu_rd && is_cram) begin
			cram_addr_hold <= cram_addr_live;
			rd_sel_q       <= rd_sel;
		end
	end

	always_comb begin
		case (rd_sel_q)
			RD_OFF:    cpu_rdata = 8'hFF;                 // open bus
			RD_NIBBLE: cpu_rdata = {4'hF, cram_q[3:0]};   // 4-bit MBC2 cells
			RD_CLOCK:  cpu_rdata = 8'h00;                 // no clock registers here
			default:   cpu_rdata = cram_q;
		endcase
	end

endmodule

// ==== src/cart_ram.sv ====
// banked byte-wide cartridge RAM with registered read
module cart_ram #(
	parameter int CRAM_BANK_BITS = 4  // 4 gives 16 x 8 KB, 2 gives 32 KB
) (
	input  logic                       clk_sys,
	input  logic [CRAM_BANK_BITS+12:0] cram_addr,
	input  logic                       cram_we,
	input  logic [7:0]                 cram_wdata,
	output logic [7:0]                 cram_q
);

	localparam int DEPTH = 1 << (CRAM_BANK_BITS + 13);  // 8 KB per bank

	logic [7:0] mem [DEPTH];

	// q only moves on non-write cycles, so a read result survives a later write
	always_ff @(posedge clk_sys) begin
		if (cram_we)
			mem[cram_addr] <= cram_wdata;
		else
			cram_q <= mem[cram_addr];
	end

endmodule

// ==== src/cart_mapper.sv ====
// mapper top level wiring header parser, controller registers, address map and cart RAM
module cart_mapper #(
	parameter int CRAM_BANK_BITS = 4
) (
	input  logic                             clk_sys,
	input  logic                             reset,
	// download stream
	input  logic                             dl_active,
	input  logic                             dl_wr,
	input  logic [cart_pkg::DL_ADDR_W-1:0]   dl_addr,
	input  logic [15:0]                      dl_data,
	// CPU bus
	input  logic [15:0]                      cpu_addr,
	input  logic                             cpu_rd,
	input  logic                             cpu_wr,
	input  logic [7:0]                       cpu_wdata,
	output logic [7:0]                       cpu_rdata,
	output logic [cart_pkg::ROM_WADDR_W-1:0] rom_waddr,
	output logic                             rom_byte_hi,
	// header status for the console core
	output logic                             cgb_game,
	output logic                             ram_present
);
	import cart_pkg::*;

	mbc_kind_t                  mbc_kind;
	logic [ROM_BANK_W-1:0]      rom_mask;
	logic [RAM_BANK_W-1:0]      ram_mask;
	logic [ROM_BANK_W-1:0]      rom_bank;
	logic [RAM_BANK_W-1:0]      ram_bank;
	logic                       mbc1_mode;
	logic                       rtc_mode;
	logic                       ram_enabled;
	logic [CRAM_BANK_BITS+12:0] cram_addr;
	logic                       cram_we;
	logic [7:0]                 cram_wdata;
	logic [7:0]                 cram_q;

	// ------------------------------------------------------------------------
	// configuration from the header, then registers and address map
	// ------------------------------------------------------------------------

	cart_header i_cart_header (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.dl_active   (dl_active),
		.dl_wr       (dl_wr),
		.dl_addr     (dl_addr),
		.dl_data     (dl_data),
		.mbc_kind    (mbc_kind),
		.rom_mask    (rom_mask),
		.ram_mask    (ram_mask),
		.ram_present (ram_present),
		.cgb_game    (cgb_game)
	);

	mbc_regs i_mbc_regs (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.dl_active   (dl_active),
		.cpu_addr    (cpu_addr),
		.cpu_wr      (cpu_wr),
		.cpu_wdata   (cpu_wdata),
		.mbc_kind    (mbc_kind),
		.rom_bank    (rom_bank),
		.ram_bank    (ram_bank),
		.mbc1_mode   (mbc1_mode),
		.rtc_mode    (rtc_mode),
		.ram_enabled (ram_enabled)
	);

	cart_addr_map #(
		.CRAM_BANK_BITS (CRAM_BANK_BITS)
	) i_cart_addr_map (
		.clk_sys     (clk_sys),
		.cpu_addr    (cpu_addr),
		.cpu_rd      (cpu_rd),
		.cpu_wr      (cpu_wr),
		.cpu_wdata   (cpu_wdata),
		.mbc_kind    (mbc_kind),
		.rom_mask    (rom_mask),
		.ram_mask    (ram_mask),
		.rom_bank    (rom_bank),
		.ram_bank    (ram_bank),
		.mbc1_mode   (mbc1_mode),
		.rtc_mode    (rtc_mode),
		.ram_enabled (ram_enabled),
		.rom_waddr   (rom_waddr),
		.rom_byte_hi (rom_byte_hi),
		.cram_addr   (cram_addr),
		.cram_we     (cram_we),
		.cram_wdata  (cram_wdata),
		.cpu_rdata   (cpu_rdata),
		.cram_q      (cram_q)
	);

	cart_ram #(
		.CRAM_BANK_BITS (CRAM_BANK_BITS)
	) i_cart_ram (
		.clk_sys    (clk_sys),
		.cram_addr  (cram_addr),
		.cram_we    (cram_we),
		.cram_wdata (cram_wdata),
		.cram_q     (cram_q)
	);

endmodule

// ==== include/tb_cart_tasks.svh ====
// testbench tasks for value check, reset, header download, CPU write, CPU read and ROM address
`ifndef TB_CART_TASKS_SVH
`define TB_CART_TASKS_SVH

// every compare in the testbench ends up here
task automatic check_value(input string what, input int expected, input int actual);
	assert (expected == actual) else begin
		$display("FAIL %s %s: expected %0h, actual %0h", test_name, what, expected, actual);
		$display("ERRORS FOUND");
		$fatal(1, "stopped at first mismatch");
	end
endtask

task automatic apply_reset();
	@(posedge clk_sys);
	#1 reset = 1'b1;
	repeat (8) @(posedge clk_sys);
	#1 reset = 1'b0;
endtask

// ------------------------------------------------------------------------
// header download in three words covering 143h and 147h-149h
// ------------------------------------------------------------------------

task automatic load_header(input logic [7:0] cart_type, input logic [7:0] rom_code,
	input logic [7:0] ram_code, input logic [7:0] cgb_flag);
	logic [24:0] addr_list [3];
	logic [15:0] word_list [3];
	addr_list = '{25'h142, 25'h146, 25'h148};
	word_list = '{{cgb_flag, 8'h00}, {cart_type, 8'h00}, {ram_code, rom_code}};  // odd byte high
	@(posedge clk_sys);
	#1 dl_active = 1'b1;
	for (int i = 0; i < 3; i++) begin
		dl_wr   = 1'b1;
		dl_addr = addr_list[i];
		dl_data = word_list[i];
		@(posedge clk_sys);
		#1;
	end
	dl_wr     = 1'b0;
	dl_active = 1'b0;  // registers leave their held reset state here
endtask

// colour and RAM flags once the header is in
task automatic status_check(input logic cgb_expected, input logic ram_expected);
	check_value("cgb_game", int'(cgb_expected), int'(cgb_game));
	check_value("ram_present", int'(ram_expected), int'(ram_present));
endtask

task automatic cpu_write(input logic [15:0] addr, input logic [7:0] data);
	@(posedge clk_sys);
	#1 cpu_addr = addr;
	cpu_wdata = data;
	cpu_wr    = 1'b1;
	@(posedge clk_sys);  // stored or latched at this edge
	#1 cpu_wr = 1'b0;
endtask

// data is due one cycle after the strobe
task automatic cpu_read(input logic [15:0] addr, input logic [7:0] expected);
	@(posedge clk_sys);
	#1 cpu_addr = addr;
	cpu_rd = 1'b1;
	@(posedge clk_sys);
	#1 cpu_rd = 1'b0;
	check_value("cpu_rdata", int'(expected), int'(cpu_rdata));
endtask

// word address is bank * 8192 plus address bits 13-1 with the odd byte in the high half
task automatic rom_check(input logic [15:0] addr, input int bank);
	@(posedge clk_sys);
	#1 cpu_addr = addr;
	#1;
	check_value("rom_waddr", bank * 8192 + int'(addr[13:1]), int'(rom_waddr));
	check_value("rom_byte_hi", int'(addr[0]), int'(rom_byte_hi));
endtask

`endif

// ==== tests/tb_cart_mapper.sv ====
// top testbench with clock, reset, DUT, controller tests, watchdog and pass/fail report
module tb_cart_mapper;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int CYCLE_LIMIT = 2000;  // tests take a few hundred cycles at most

	logic        clk_sys = 1'b0;
	logic        reset;
	logic        dl_active, dl_wr;
	logic [24:0] dl_addr;
	logic [15:0] dl_data;
	logic [15:0] cpu_addr;
	logic        cpu_rd, cpu_wr;
	logic [7:0]  cpu_wdata;
	logic [7:0]  cpu_rdata;
	logic [21:0] rom_waddr;
	logic        rom_byte_hi, cgb_game, ram_present;
	string       test_name = "init";
	int          seed = 62526;
	int          cycles = 0;

	always #2 clk_sys = ~clk_sys;  // 4 ns period

	cart_mapper #(.CRAM_BANK_BITS(4)) i_cart_mapper (
		.clk_sys(clk_sys), .reset(reset),
		.dl_active(dl_active), .dl_wr(dl_wr), .dl_addr(dl_addr), .dl_data(dl_data),
		.cpu_addr(cpu_addr), .cpu_rd(cpu_rd), .cpu_wr(cpu_wr), .cpu_wdata(cpu_wdata),
		.cpu_rdata(cpu_rdata), .rom_waddr(rom_waddr), .rom_byte_hi(rom_byte_hi),
		.cgb_game(cgb_game), .ram_present(ram_present)
	);

	`include "tb_cart_tasks.svh"

	// ------------------------------------------------------------------------
	// watchdog
	// ------------------------------------------------------------------------

	always @(posedge clk_sys) begin
		cycles <= cycles + 1;
		if (cycles >= CYCLE_LIMIT) begin
			$display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
			$display("ERRORS FOUND");
			$fatal(1, "watchdog expired");
		end
	end

	// ------------------------------------------------------------------------
	// tests
	// ------------------------------------------------------------------------

	initial begin
		logic [7:0] d0, d2;
		reset     = 1'b1;
		dl_active = 1'b0;
		dl_wr     = 1'b0;
		dl_addr   = '0;
		dl_data   = '0;
		cpu_addr  = '0;
		cpu_rd    = 1'b0;
		cpu_wr    = 1'b0;
		cpu_wdata = '0;

		test_name = "no_mbc";  // plain 32 KB where 4000h is word 8192
		apply_reset();
		load_header(8'h00, 8'h00, 8'h00, 8'h00);
		status_check(1'b0, 1'b0);          // mono game without RAM
		rom_check(16'h4000, 1);
		rom_check(16'h0001, 0);

		test_name = "mbc1_rom";
		apply_reset();
		load_header(8'h01, 8'h02, 8'h00, 8'h00);  // 8 banks, mask 7
		cpu_write(16'h2000, 8'h00);
		rom_check(16'h4000, 1);            // zero reads as bank 1
		cpu_write(16'h2000, 8'h1F);
		rom_check(16'h6001, 'h1F & 'h07);
		apply_reset();
		load_header(8'h01, 8'h06, 8'h00, 8'h00);  // 128 banks so bit 5 survives the mask
		cpu_write(16'h2000, 8'h01);
		cpu_write(16'h4000, 8'h01);        // mode 0 takes these as upper bits
		rom_check(16'h4000, 'h01 | (1 << 5));

		test_name = "mbc5_rom";
		apply_reset();
		load_header(8'h19, 8'h08, 8'h00, 8'h80);  // 512 banks, colour compatible
		status_check(1'b1, 1'b0);
		cpu_write(16'h2000, 8'h34);
		cpu_write(16'h3000, 8'h01);
		rom_check(16'h4000, 'h134);
		rom_check(16'h7FFF, 'h134);

		test_name = "ram_banks";
		apply_reset();
		load_header(8'h1B, 8'h00, 8'h04, 8'h00);  // MBC5 with 128 KB RAM
		status_check(1'b0, 1'b1);
		cpu_read(16'hA000, 8'hFF);         // still closed
		cpu_write(16'h0000, 8'h0A);
		d0 = 8'($random(seed));
		d2 = 8'($random(seed));
		if (d2 == d0)
			d2 = ~d0;  // keep the two banks distinguishable
		cpu_write(16'h4000, 8'h00);
		cpu_write(16'hA123, d0);
		cpu_write(16'h4000, 8'h02);
		cpu_write(16'hA123, d2);
		cpu_read(16'hA123, d2);
		cpu_write(16'h4000, 8'h00);
		cpu_read(16'hA123, d0);

		test_name = "mbc2_nibble";
		apply_reset();
		load_header(8'h05, 8'h00, 8'h00, 8'h00);
		cpu_write(16'h0000, 8'h0A);
		d0 = 8'($random(seed));
		if (d0[7:4] == 4'hF)
			d0[7:4] = 4'h0;  // stored upper nibble must differ from the read fill
		cpu_write(16'hA010, d0);
		cpu_read(16'hA010, {4'hF, d0[3:0]});  // upper nibble floats high

		test_name = "mbc3_clock";
		apply_reset();
		load_header(8'h10, 8'h00, 8'h03, 8'hC0);  // colour only game with 32 KB RAM
		status_check(1'b1, 1'b1);
		cpu_write(16'h0000, 8'h0A);
		d0 = 8'($random(seed));
		if (d0 == 8'h00)
			d0 = 8'hA5;  // nonzero so the clock read stands apart
		cpu_write(16'hA020, d0);
		cpu_read(16'hA020, d0);
		cpu_write(16'h4000, 8'h08);        // clock register selected
		cpu_read(16'hA020, 8'h00);
		cpu_write(16'h4000, 8'h00);        // back to RAM bank 0
		cpu_read(16'hA020, d0);

		$display("NO ERRORS");
		$finish;
	end

endmodule

// ==== flist.f ====
+incdir+include
src/cart_pkg.sv
src/cart_header.sv
src/mbc_regs.sv
src/cart_addr_map.sv
src/cart_ram.sv
src/cart_mapper.sv
tests/tb_cart_mapper.sv

// ==== Makefile ====
# Verilator build and run of the cart mapper testbench
TOP = tb_cart_mapper

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --timescale 1ns/100ps \
		-f flist.f --top-module $(TOP) -Mdir obj_dir

# pass only when the simulation printed the pass line
run: compile
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "^NO ERRORS$$"

clean:
	rm -rf obj_dir
